/* flist.f */
+incdir+rtl
rtl/video_pkg.sv
rtl/clk_enable_gen.sv
rtl/raster_counter.sv
rtl/mem_slot_timer.sv
rtl/slot_ram.sv
rtl/cpu_bus_port.sv
rtl/gfx_fetch.sv
rtl/bubsys_video_mem.sv
verification/tb_clk_gen.sv
verification/bubsys_video_mem_assertions.sv
verification/bubsys_video_mem_tb.sv

/* rtl/bubsys_video_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module bubsys_video_mem
(
    input   wire                        i_EMU_MCLK,
    input   wire                        i_arst_n,
    input   wire                        i_EMU_CLK18MNCEN_n,
    input   wire video_pkg::cpu_req_t   i_cpu,
    input   wire video_pkg::cpu_cs_t    i_cs,
    output  logic [15:0]                o_cpu_dout,
    output  logic                       o_cpu_ack,
    output  video_pkg::cen_t            o_cen,
    output  logic                       o_vblank_n,
    output  video_pkg::fetch_t          o_fetch
);

video_pkg::raster_t         raster;
video_pkg::slot_t           slot;
video_pkg::ram_ctrl_t       scroll_ctrl;
video_pkg::ram_ctrl_t       vram_ctrl;
logic   [7:0]               scroll_dout;
logic   [15:0]              vram_dout;
logic   [`VID_RAM_AW-1:0]   gfx_addr;

//////////////////////////////////////////////////
// Timing
//////////////////////////////////////////////////

clk_enable_gen u_clk_enable_gen
(
    .i_EMU_MCLK         (i_EMU_MCLK         ),
    .i_arst_n           (i_arst_n           ),
    .i_EMU_CLK18MNCEN_n (i_EMU_CLK18MNCEN_n ),
    .o_cen              (o_cen              )
);

raster_counter u_raster_counter
(
    .i_EMU_MCLK         (i_EMU_MCLK         ),
    .i_arst_n           (i_arst_n           ),
    .i_cen              (o_cen              ),
    .o_raster           (raster             ),
    .o_vblank_n         (o_vblank_n         )
);

mem_slot_timer u_mem_slot_timer
(
    .i_EMU_MCLK         (i_EMU_MCLK         ),
    .i_arst_n           (i_arst_n           ),
    .i_EMU_CLK18MNCEN_n (i_EMU_CLK18MNCEN_n ),
    .i_cen              (o_cen              ),
    .i_raster           (raster             ),
    .o_slot             (slot               )
);

//////////////////////////////////////////////////
// Shared RAMs and their two owners
//////////////////////////////////////////////////

cpu_bus_port u_cpu_bus_port
(
    .i_EMU_MCLK         (i_EMU_MCLK         ),
    .i_arst_n           (i_arst_n           ),
    .i_cpu              (i_cpu              ),
    .i_cs               (i_cs               ),
    .i_raster           (raster             ),
    .i_slot             (slot               ),
    .i_gfx_addr         (gfx_addr           ),
    .i_scroll_dout      (scroll_dout        ),
    .i_vram_dout        (vram_dout          ),
    .o_scroll_ctrl      (scroll_ctrl        ),
    .o_vram_ctrl        (vram_ctrl          ),
    .o_cpu_dout         (o_cpu_dout         ),
    .o_cpu_ack          (o_cpu_ack          )
);

gfx_fetch u_gfx_fetch
(
    .i_EMU_MCLK         (i_EMU_MCLK         ),
    .i_arst_n           (i_arst_n           ),
    .i_cen              (o_cen              ),
    .i_raster           (raster             ),
    .i_slot             (slot               ),
    .i_scroll_dout      (scroll_dout        ),
    .i_vram_dout        (vram_dout          ),
    .o_gfx_addr         (gfx_addr           ),
    .o_fetch            (o_fetch            )
);

slot_ram #(.T_DATA(logic [7:0])) u_scroll_ram
(
    .i_EMU_MCLK         (i_EMU_MCLK         ),
    .i_ctrl             (scroll_ctrl        ),
    .i_din              (i_cpu.wdata[7:0]   ),
    .o_dout             (scroll_dout        )
);

slot_ram #(.T_DATA(logic [15:0])) u_vram
(
    .i_EMU_MCLK         (i_EMU_MCLK         ),
    .i_ctrl             (vram_ctrl          ),
    .i_din              (i_cpu.wdata        ),
    .o_dout             (vram_dout          )
);

endmodule

`default_nettype wire

/* rtl/clk_enable_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module clk_enable_gen
(
    input   wire                i_EMU_MCLK,
    input   wire                i_arst_n,
    input   wire                i_EMU_CLK18MNCEN_n,
    output  video_pkg::cen_t    o_cen
);

localparam int CNT_W = $clog2(`VID_CEN_DIV);
localparam logic [CNT_W-1:0] LAST_PHASE = CNT_W'(`VID_CEN_DIV - 1);

logic   [CNT_W-1:0] phase_cnt;      // Position in the six enable cycle
logic   [3:0]       cen_pattern;    // {9P, 9N, 6P, 6N}, low = active next enable

// Pattern loaded now shows up on the following 18 MHz enable
always_ff @(posedge i_EMU_MCLK or negedge i_arst_n)
begin
    if(!i_arst_n)
    begin
        phase_cnt   <= LAST_PHASE;  // First enable wraps to phase 0
        cen_pattern <= 4'b1111;     // Nothing active
    end
    else if(!i_EMU_CLK18MNCEN_n)
    begin
        phase_cnt <= (phase_cnt == LAST_PHASE) ? '0 : phase_cnt + 1'b1;

        case(phase_cnt)
            0:       cen_pattern <= 4'b0110; // 9P and 6N
            1:       cen_pattern <= 4'b1001; // 9N and 6P
            2:       cen_pattern <= 4'b0111; // 9P only
            3:       cen_pattern <= 4'b1010; // 9N and 6N
            4:       cen_pattern <= 4'b0101; // 9P and 6P
            5:       cen_pattern <= 4'b1011; // 9N only
            default: cen_pattern <= 4'b1111;
        endcase
    end
end

// Qualified by the 18 MHz enable, so each lasts one MCLK
assign o_cen = video_pkg::cen_t'(cen_pattern | {4{i_EMU_CLK18MNCEN_n}});

endmodule

`default_nettype wire

/* rtl/cpu_bus_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module cpu_bus_port
(
    input   wire                        i_EMU_MCLK,
    input   wire                        i_arst_n,
    input   wire video_pkg::cpu_req_t   i_cpu,
    input   wire video_pkg::cpu_cs_t    i_cs,
    input   wire video_pkg::raster_t    i_raster,
    input   wire video_pkg::slot_t      i_slot,
    input   wire [`VID_RAM_AW-1:0]      i_gfx_addr,
    input   wire [7:0]                  i_scroll_dout,
    input   wire [15:0]                 i_vram_dout,
    output  video_pkg::ram_ctrl_t       o_scroll_ctrl,
    output  video_pkg::ram_ctrl_t       o_vram_ctrl,
    output  logic [15:0]                o_cpu_dout,
    output  logic                       o_cpu_ack
);

logic                       cpu_slot;   // Pixel 0 of each 4 pixel group
logic                       armed;      // Request taken, waiting for strobe
logic                       done;       // Acked, waiting for req to drop
logic                       access;     // Strobe window of an armed cycle
logic                       access_q;
logic                       wr_go;
logic   [`VID_RAM_AW-1:0]   ram_addr;
logic   [15:0]              rd_mux;
logic   [15:0]              rd_latch;

//////////////////////////////////////////////////
// Slot ownership and cycle tracking
//////////////////////////////////////////////////

assign cpu_slot = (i_raster.h_cnt[1:0] == `VID_CPU_SLOT);
assign ram_addr = cpu_slot ? i_cpu.addr[`VID_RAM_AW-1:0] : i_gfx_addr;

// Reads ride TIME1, writes ride TIME2
assign access = i_cpu.req & armed & cpu_slot &
                (i_cpu.rw ? i_slot.time1 : ~i_slot.time2);
assign wr_go  = access & ~i_cpu.rw;

always_ff @(posedge i_EMU_MCLK or negedge i_arst_n)
begin
    if(!i_arst_n)
    begin
        armed    <= 1'b0;
        done     <= 1'b0;
        access_q <= 1'b0;
    end
    else
    begin
        access_q <= access;
        if(o_cpu_ack)
        begin
            armed <= 1'b0;
            done  <= 1'b1;
        end
        else if(!i_cpu.req) // Bus cycle over
        begin
            armed <= 1'b0;
            done  <= 1'b0;
        end
        else if(!armed && !done && cpu_slot && !i_slot.champx)
        begin
            armed <= 1'b1; // Only at slot start, address held all slot
        end
    end
end

// One MCLK after the last write edge or latch edge
assign o_cpu_ack = access_q & ~access & i_cpu.req;

//////////////////////////////////////////////////
// Write strobes
//////////////////////////////////////////////////

assign o_scroll_ctrl = '{addr:   ram_addr,
                         we_u_n: 1'b1, // 8 bit part on the lower lane
                         we_l_n: ~(wr_go & ~i_cs.vzcs_n & ~i_cpu.lds_n)};

assign o_vram_ctrl   = '{addr:   ram_addr,
                         we_u_n: ~(wr_go & ~i_cs.vcs1_n & ~i_cpu.uds_n),
                         we_l_n: ~(wr_go & ~i_cs.vcs1_n & ~i_cpu.lds_n)};

//////////////////////////////////////////////////
// Read path
//////////////////////////////////////////////////

always_comb
begin
    case({i_cs.vzcs_n, i_cs.vcs1_n})
        2'b01:   rd_mux = {8'hFF, i_scroll_dout}; // Upper byte pulled up
        2'b10:   rd_mux = i_vram_dout;
        default: rd_mux = 16'hFFFF;               // Nothing selected
    endcase
end

// TIME1 latch, holds through ack until the next read
always_ff @(posedge i_EMU_MCLK)
begin
    if(access && i_cpu.rw)
        rd_latch <= rd_mux;
end

assign o_cpu_dout = rd_latch;

endmodule

`default_nettype wire

/* rtl/gfx_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module gfx_fetch
(
    input   wire                        i_EMU_MCLK,
    input   wire                        i_arst_n,
    input   wire video_pkg::cen_t       i_cen,
    input   wire video_pkg::raster_t    i_raster,
    input   wire video_pkg::slot_t      i_slot,
    input   wire [7:0]                  i_scroll_dout,
    input   wire [15:0]                 i_vram_dout,
    output  logic [`VID_RAM_AW-1:0]     o_gfx_addr,
    output  video_pkg::fetch_t          o_fetch
);

logic                       gfx_slot;
logic                       rd_pend;    // VRTIME seen in this graphics slot
logic                       latch_now;
logic                       fetch_valid;
logic   [`VID_RAM_AW-1:0]   fetch_addr;
logic   [15:0]              tile_q;
logic   [7:0]               scroll_q;

// Tile row from v[7:3], tile column from h[8:3]
assign o_gfx_addr = {i_raster.v_cnt[7:3], i_raster.h_cnt[8:3]};
assign gfx_slot   = (i_raster.h_cnt[1:0] == `VID_GFX_SLOT);
assign latch_now  = rd_pend & ~i_cen.p6_n; // Pixel boundary ending the slot

always_ff @(posedge i_EMU_MCLK or negedge i_arst_n)
begin
    if(!i_arst_n)
    begin
        rd_pend     <= 1'b0;
        fetch_valid <= 1'b0;
    end
    else
    begin
        fetch_valid <= latch_now; // Single MCLK pulse
        if(latch_now)
            rd_pend <= 1'b0;
        else if(gfx_slot && !i_slot.vrtime)
            rd_pend <= 1'b1;
    end
end

// Address still this slot's at the latch edge
always_ff @(posedge i_EMU_MCLK)
begin
    if(latch_now)
    begin
        fetch_addr <= o_gfx_addr;
        tile_q     <= i_vram_dout;
        scroll_q   <= i_scroll_dout;
    end
end

assign o_fetch = '{valid:      fetch_valid,
                   vram_addr:  fetch_addr,
                   tile_word:  tile_q,
                   scroll_val: scroll_q};

endmodule

`default_nettype wire

/* rtl/mem_slot_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_slot_timer
(
    input   wire                        i_EMU_MCLK,
    input   wire                        i_arst_n,
    input   wire                        i_EMU_CLK18MNCEN_n,
    input   wire video_pkg::cen_t       i_cen,
    input   wire video_pkg::raster_t    i_raster,
    output  video_pkg::slot_t           o_slot
);

logic           dff_1hf;    // 1H delayed one pixel, high on even pixels
logic   [3:0]   sr_slot;    // [3] is the first stage
logic           clk6m_lvl;  // Rebuilt 6 MHz clock level

// 1HF flip-flop
always_ff @(posedge i_EMU_MCLK or negedge i_arst_n)
begin
    if(!i_arst_n)
        dff_1hf <= 1'b0;
    else if(!i_cen.p6_n)
        dff_1hf <= i_raster.h_cnt[0];
end

// Four stage shifter on the 18 MHz enable
always_ff @(posedge i_EMU_MCLK or negedge i_arst_n)
begin
    if(!i_arst_n)
        sr_slot <= 4'b0000;
    else if(!i_EMU_CLK18MNCEN_n)
        sr_slot <= {dff_1hf, sr_slot[3:1]};
end

// Low between the 6 MHz falling and rising enables
always_ff @(posedge i_EMU_MCLK or negedge i_arst_n)
begin
    if(!i_arst_n)
        clk6m_lvl <= 1'b1;
    else if(!i_cen.n6_n)
        clk6m_lvl <= 1'b0;
    else if(!i_cen.p6_n)
        clk6m_lvl <= 1'b1;
end

// Strobe decode, last third of an even pixel for TIME1/TIME2
assign o_slot.time1  = ~(~dff_1hf | clk6m_lvl);    // NOR
assign o_slot.time2  = ~(dff_1hf & sr_slot[2]);     // NAND
assign o_slot.vrtime = ~(dff_1hf & ~sr_slot[3]);    // First third of even pixel
assign o_slot.champx = sr_slot[2] | sr_slot[1];     // OR, low first two thirds

endmodule

`default_nettype wire

/* rtl/raster_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module raster_counter
(
    input   wire                    i_EMU_MCLK,
    input   wire                    i_arst_n,
    input   wire video_pkg::cen_t   i_cen,
    output  video_pkg::raster_t     o_raster,
    output  logic                   o_vblank_n
);

localparam logic [8:0] H_LAST = 9'(`VID_H_TOTAL - 1);
localparam logic [8:0] V_LAST = 9'(`VID_V_TOTAL - 1);

logic   [8:0]   h_cnt;
logic   [8:0]   v_cnt;

//////////////////////////////////////////////////
// Pixel and line counters
//////////////////////////////////////////////////

always_ff @(posedge i_EMU_MCLK or negedge i_arst_n)
begin
    if(!i_arst_n)
    begin
        h_cnt <= '0;
        v_cnt <= '0;
    end
    else if(!i_cen.p6_n) // One step per pixel
    begin
        if(h_cnt == H_LAST)
        begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1; // Next line
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end
    end
end

assign o_raster   = '{v_cnt: v_cnt, h_cnt: h_cnt};
assign o_vblank_n = (v_cnt < 9'(`VID_V_ACTIVE)); // Low on the blank lines

endmodule

`default_nettype wire

/* rtl/slot_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module slot_ram
#(
    parameter type T_DATA = logic [15:0]
)
(
    input   wire                        i_EMU_MCLK,
    input   wire video_pkg::ram_ctrl_t  i_ctrl,
    input   wire T_DATA                 i_din,
    output  T_DATA                      o_dout
);

localparam int W     = $bits(T_DATA);
localparam int DEPTH = 2 ** `VID_RAM_AW;

logic   [W-1:0] mem [DEPTH];
logic   [W-1:0] din_bits;

assign din_bits = i_din;

// Upper lane only exists on wide payloads
generate
    if(W > 8)
    begin : g_two_lanes
        always_ff @(posedge i_EMU_MCLK)
        begin
            if(!i_ctrl.we_l_n)
                mem[i_ctrl.addr][7:0] <= din_bits[7:0];     // Lower lane
            if(!i_ctrl.we_u_n)
                mem[i_ctrl.addr][W-1:8] <= din_bits[W-1:8]; // Upper lane
            o_dout <= mem[i_ctrl.addr];                     // Registered read, old data on write
        end
    end
    else
    begin : g_one_lane
        always_ff @(posedge i_EMU_MCLK)
        begin
            if(!i_ctrl.we_l_n)
                mem[i_ctrl.addr] <= din_bits;   // Lower lane only
            o_dout <= mem[i_ctrl.addr];
        end
    end
endgenerate

endmodule

`default_nettype wire

/* rtl/video_config.svh */
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// Raster geometry in 6 MHz pixels and lines
`define VID_H_TOTAL     384     // Pixels per line
`define VID_V_TOTAL     264     // Lines per frame
`define VID_V_ACTIVE    224     // Visible lines, blank from here on

// Scroll RAM and tile VRAM share one address width
`define VID_RAM_AW      11

// Enable pattern length in 18 MHz enables
`define VID_CEN_DIV     6

// Pixel phase within a 4 pixel group, from h[1:0]
`define VID_CPU_SLOT    2'd0    // CPU owns the RAMs
`define VID_GFX_SLOT    2'd2    // Graphics fetch owns the RAMs

`endif

/* rtl/video_pkg.sv */
`default_nettype none

`include "video_config.svh"

package video_pkg;

    // Clock enables, all active low, valid for one MCLK
    typedef struct packed {
        logic               p9_n;       // 9 MHz rising edge
        logic               n9_n;       // 9 MHz falling edge
        logic               p6_n;       // 6 MHz rising edge, pixel advance
        logic               n6_n;       // 6 MHz falling edge
    } cen_t;

    // Pixel position
    typedef struct packed {
        logic   [8:0]       v_cnt;
        logic   [8:0]       h_cnt;
    } raster_t;

    // Memory slot strobes
    typedef struct packed {
        logic               time1;      // Read latch enable, high
        logic               time2;      // Write enable, low
        logic               vrtime;     // Video read time, low
        logic               champx;     // Slot mux phase, low at slot start
    } slot_t;

    // 68000 style bus request
    typedef struct packed {
        logic               req;
        logic               rw;         // 1 = read
        logic               uds_n;
        logic               lds_n;
        logic   [14:0]      addr;       // Word address
        logic   [15:0]      wdata;
    } cpu_req_t;

    // Chip selects, one low per request
    typedef struct packed {
        logic               vzcs_n;     // Scroll RAM
        logic               vcs1_n;     // Tile VRAM
    } cpu_cs_t;

    typedef struct packed {
        logic   [`VID_RAM_AW-1:0] addr;
        logic               we_u_n;     // Upper lane write, low
        logic               we_l_n;     // Lower lane write, low
    } ram_ctrl_t;

    // One graphics-slot fetch result
    typedef struct packed {
        logic               valid;
        logic   [`VID_RAM_AW-1:0] vram_addr;
        logic   [15:0]      tile_word;
        logic   [7:0]       scroll_val;
    } fetch_t;

endpackage

`default_nettype wire

/* verification/bubsys_video_mem_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module bubsys_video_mem_assertions
(
    input   wire                        i_EMU_MCLK,
    input   wire                        i_arst_n,
    input   wire video_pkg::cen_t       i_cen,
    input   wire video_pkg::cpu_req_t   i_cpu,
    input   wire video_pkg::slot_t      i_slot,
    input   wire video_pkg::ram_ctrl_t  i_scroll_ctrl,
    input   wire video_pkg::ram_ctrl_t  i_vram_ctrl,
    input   wire                        i_cpu_ack
);

logic   any_we;     // Some lane of some RAM is writing

assign any_we = !i_scroll_ctrl.we_u_n || !i_scroll_ctrl.we_l_n ||
                !i_vram_ctrl.we_u_n   || !i_vram_ctrl.we_l_n;

//////////////////////////////////////////////////
// Enable generator
//////////////////////////////////////////////////

// Both edges of one derived clock never share an MCLK
a_cen_9m_excl: assert property (@(posedge i_EMU_MCLK) disable iff (!i_arst_n)
    !(!i_cen.p9_n && !i_cen.n9_n))
    else $error("9 MHz rising and falling enables active together");

a_cen_6m_excl: assert property (@(posedge i_EMU_MCLK) disable iff (!i_arst_n)
    !(!i_cen.p6_n && !i_cen.n6_n))
    else $error("6 MHz rising and falling enables active together");

//////////////////////////////////////////////////
// CPU bus port
//////////////////////////////////////////////////

a_ack_in_req: assert property (@(posedge i_EMU_MCLK) disable iff (!i_arst_n)
    $rose(i_cpu_ack) |-> i_cpu.req)     // No ack without a pending cycle
    else $error("CPU acknowledge rose with no request pending");

a_we_in_time2: assert property (@(posedge i_EMU_MCLK) disable iff (!i_arst_n)
    any_we |-> !i_slot.time2)           // Strobes gated by TIME2
    else $error("RAM write strobe active outside TIME2");

endmodule

`default_nettype wire

/* verification/bubsys_video_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module bubsys_video_mem_tb;

localparam int AW          = `VID_RAM_AW;
localparam int DEPTH       = 2 ** AW;
localparam int VRAM_OPS    = 128;
localparam int SCROLL_OPS  = 64;
localparam int CEN_WINDOWS = 48;       // Windows of six enables checked
localparam int NUM_REQ     = 2 * DEPTH + 3 * VRAM_OPS + 3 * SCROLL_OPS;
localparam int FRAME_MCLK  = `VID_H_TOTAL * `VID_V_TOTAL * 12;
localparam int CYCLE_LIMIT = 2 * FRAME_MCLK + 64 * NUM_REQ;

localparam video_pkg::cpu_cs_t CS_VRAM   = video_pkg::cpu_cs_t'(2'b10);
localparam video_pkg::cpu_cs_t CS_SCROLL = video_pkg::cpu_cs_t'(2'b01);
localparam video_pkg::cpu_cs_t CS_NONE   = video_pkg::cpu_cs_t'(2'b11);

logic                   mclk;
logic                   arst_n;
logic                   clk18_en_n = 1'b1;
logic   [1:0]           en_phase   = 2'd0;
video_pkg::cpu_req_t    cpu_req;
video_pkg::cpu_cs_t     cpu_cs;
logic   [15:0]          cpu_dout;
logic                   cpu_ack;
video_pkg::cen_t        cen;
logic                   vblank_n;
video_pkg::fetch_t      fetch;

logic   [15:0]          vram_model   [DEPTH];   // Scoreboard copies of both RAMs
logic   [7:0]           scroll_model [DEPTH];
video_pkg::fetch_t      exp_fetch;
logic   [8:0]           ref_h;                  // Raster model, pixel in line
logic   [8:0]           ref_v;                  // Raster model, line in frame
logic   [AW-1:0]        exp_addr;
integer                 seed;
int                     cycle_cnt    = 0;
int                     tests_passed = 0;
int                     tests_failed = 0;
bit                     fetch_on     = 1'b0;    // Models complete after the fill
int                     fetch_checks = 0;
int                     fetch_errs   = 0;
bit                     in_blank     = 1'b0;
bit                     blank_done   = 1'b0;
int                     blank_p6     = 0;
int                     blank_errs   = 0;

tb_clk_gen u_tb_clk_gen
(
    .o_clk              (mclk           ),
    .o_arst_n           (arst_n         )
);

bubsys_video_mem u_bubsys_video_mem
(
    .i_EMU_MCLK         (mclk           ),
    .i_arst_n           (arst_n         ),
    .i_EMU_CLK18MNCEN_n (clk18_en_n     ),
    .i_cpu              (cpu_req        ),
    .i_cs               (cpu_cs         ),
    .o_cpu_dout         (cpu_dout       ),
    .o_cpu_ack          (cpu_ack        ),
    .o_cen              (cen            ),
    .o_vblank_n         (vblank_n       ),
    .o_fetch            (fetch          )
);

// Watches the enable generator and bus port signals inside the top
bind bubsys_video_mem bubsys_video_mem_assertions u_assertions
(
    .i_EMU_MCLK         (i_EMU_MCLK     ),
    .i_arst_n           (i_arst_n       ),
    .i_cen              (o_cen          ),
    .i_cpu              (i_cpu          ),
    .i_slot             (slot           ),
    .i_scroll_ctrl      (scroll_ctrl    ),
    .i_vram_ctrl        (vram_ctrl      ),
    .i_cpu_ack          (o_cpu_ack      )
);

//////////////////////////////////////////////////
// Compare and report
//////////////////////////////////////////////////

task automatic check_cpu_read(input logic [15:0] got, input logic [15:0] exp,
                              input string msg, inout int errs);
    if (got !== exp)
    begin
        $display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
        errs++;
    end
endtask

task automatic check_fetch(input video_pkg::fetch_t got, input video_pkg::fetch_t exp,
                           input string msg, inout int errs);
    if (got !== exp)
    begin
        $display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
        errs++;
    end
endtask

task automatic check_cen(input video_pkg::cen_t got, input video_pkg::cen_t exp,
                         input string msg, inout int errs);
    if (got !== exp)
    begin
        $display("mismatch at %0t: %s, got %b expected %b", $time, msg, got, exp);
        errs++;
    end
endtask

task automatic check_count(input int got, input int exp, input string msg, inout int errs);
    if (got != exp)
    begin
        $display("mismatch at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
        errs++;
    end
endtask

task automatic report_test(input string name, input int checks, input int errs);
    if (errs == 0)
    begin
        tests_passed++;
        $display("test %s: ok, %0d checks", name, checks);
    end
    else
    begin
        tests_failed++;
        $display("test %s: FAILED, %0d of %0d checks wrong", name, errs, checks);
    end
endtask

//////////////////////////////////////////////////
// Bus cycles
//////////////////////////////////////////////////

// Request held until the ack, then dropped on the next falling edge
task automatic cpu_access(input logic rw, input logic [14:0] addr, input logic [1:0] lanes_n,
                          input logic [15:0] wdata, input video_pkg::cpu_cs_t cs,
                          output logic [15:0] rdata);
    @(negedge mclk);
    cpu_req = '{req: 1'b1, rw: rw, uds_n: lanes_n[1], lds_n: lanes_n[0],
                addr: addr, wdata: wdata};
    cpu_cs  = cs;
    @(posedge mclk);
    while (!cpu_ack)
        @(posedge mclk);
    rdata = cpu_dout;                  // Latched data holds past the ack
    @(negedge mclk);
    cpu_req.req = 1'b0;
    cpu_cs      = CS_NONE;
endtask

task automatic read_check(input video_pkg::cpu_cs_t cs, input logic [14:0] addr,
                          input logic [15:0] exp, input string msg, inout int errs);
    logic   [15:0]  rdata;
    cpu_access(1'b1, addr, 2'b00, 16'h0000, cs, rdata);
    check_cpu_read(rdata, exp, msg, errs);
endtask

//////////////////////////////////////////////////
// Tests
//////////////////////////////////////////////////

task automatic run_enable_test();
    int en_seen = 0;
    int checks  = 0;
    int errs    = 0;
    int n_p9    = 0;
    int n_n9    = 0;
    int n_p6    = 0;
    int n_n6    = 0;
    while (en_seen <= 6 * CEN_WINDOWS)
    begin
        @(posedge mclk);
        if (clk18_en_n)
        begin
            check_cen(cen, video_pkg::cen_t'(4'hF), "enable outside 18 MHz enable", errs);
            checks++;
        end
        else
        begin
            en_seen++;
            if (en_seen > 1) // First enable still shows the reset pattern
            begin
                n_p9 += !cen.p9_n;
                n_n9 += !cen.n9_n;
                n_p6 += !cen.p6_n;
                n_n6 += !cen.n6_n;
                if ((en_seen - 1) % `VID_CEN_DIV == 0) // Window of six complete
                begin
                    check_count(n_p9, `VID_CEN_DIV / 2, "9 MHz rising per window", errs);
                    check_count(n_n9, `VID_CEN_DIV / 2, "9 MHz falling per window", errs);
                    check_count(n_p6, `VID_CEN_DIV / 3, "6 MHz rising per window", errs);
                    check_count(n_n6, `VID_CEN_DIV / 3, "6 MHz falling per window", errs);
                    checks += 4;
                    n_p9 = 0;
                    n_n9 = 0;
                    n_p6 = 0;
                    n_n6 = 0;
                end
            end
        end
    end
    report_test("enable_pattern", checks, errs);
endtask

// Every address of both RAMs gets known data
task automatic fill_rams();
    logic   [31:0]  rnd;
    logic   [15:0]  rdata;
    for (int a = 0; a < DEPTH; a++)
    begin
        rnd = $random(seed);
        cpu_access(1'b0, 15'(a), 2'b00, rnd[15:0], CS_VRAM, rdata);
        vram_model[a] = rnd[15:0];
        cpu_access(1'b0, 15'(a), 2'b10, {8'h00, rnd[23:16]}, CS_SCROLL, rdata);
        scroll_model[a] = rnd[23:16];
    end
endtask

task automatic run_vram_test();
    logic   [31:0]  rnd;
    logic   [31:0]  wdat;
    logic   [14:0]  addr;
    logic   [1:0]   lanes_n;            // {uds_n, lds_n}
    logic   [15:0]  rdata;
    int             checks = 0;
    int             errs   = 0;
    for (int i = 0; i < VRAM_OPS; i++)
    begin
        rnd     = $random(seed);
        wdat    = $random(seed);
        addr    = rnd[14:0];
        lanes_n = (rnd[17:16] == 2'b11) ? 2'b00 : rnd[17:16]; // Word, upper or lower
        cpu_access(1'b0, addr, lanes_n, wdat[15:0], CS_VRAM, rdata);
        if (!lanes_n[1])
            vram_model[addr[AW-1:0]][15:8] = wdat[15:8];
        if (!lanes_n[0])
            vram_model[addr[AW-1:0]][7:0] = wdat[7:0];
        read_check(CS_VRAM, addr, vram_model[addr[AW-1:0]], "vram read after write", errs);
        rnd = $random(seed);
        read_check(CS_VRAM, rnd[14:0], vram_model[rnd[AW-1:0]], "vram random read", errs);
        checks += 2;
    end
    report_test("vram_byte_lanes", checks, errs);
endtask

task automatic run_scroll_test();
    logic   [31:0]  rnd;
    logic   [14:0]  addr;
    logic   [15:0]  rdata;
    int             checks = 0;
    int             errs   = 0;
    for (int i = 0; i < SCROLL_OPS; i++)
    begin
        rnd  = $random(seed);
        addr = rnd[14:0];
        cpu_access(1'b0, addr, {rnd[15], 1'b0}, rnd[31:16], CS_SCROLL, rdata); // Upper lane ignored
        scroll_model[addr[AW-1:0]] = rnd[23:16];
        read_check(CS_SCROLL, addr, {8'hFF, scroll_model[addr[AW-1:0]]},
                   "scroll read after write", errs);
        rnd = $random(seed);
        read_check(CS_SCROLL, rnd[14:0], {8'hFF, scroll_model[rnd[AW-1:0]]},
                   "scroll random read", errs);
        checks += 2;
    end
    report_test("scroll_ram", checks, errs);
endtask

//////////////////////////////////////////////////
// Free running monitors
//////////////////////////////////////////////////

// 18 MHz enable, low one MCLK in four
always @(negedge mclk)
begin
    en_phase   = en_phase + 2'd1;
    clk18_en_n = (en_phase != 2'd0);
end

// Raster model steps on the 6 MHz rising enable
always @(posedge mclk)
begin
    if (!arst_n)
    begin
        ref_h = '0;
        ref_v = '0;
    end
    else
    begin
        if (fetch_on && fetch.valid)
        begin
            // Model is one pixel past the graphics slot, same tile column
            exp_addr  = {ref_v[7:3], ref_h[8:3]};
            exp_fetch = '{valid:      1'b1,
                          vram_addr:  exp_addr,
                          tile_word:  vram_model[exp_addr],
                          scroll_val: scroll_model[exp_addr]};
            check_fetch(fetch, exp_fetch, "fetch record", fetch_errs);
            fetch_checks++;
        end
        if (!cen.p6_n)
        begin
            if (ref_h == 9'(`VID_H_TOTAL - 1))
            begin
                ref_h = '0;
                ref_v = (ref_v == 9'(`VID_V_TOTAL - 1)) ? 9'd0 : ref_v + 9'd1;
            end
            else
            begin
                ref_h = ref_h + 9'd1;
            end
        end
    end
end

// Counts pixels of the first complete blank period
always @(posedge mclk)
begin
    if (arst_n && !blank_done)
    begin
        if (!vblank_n)
        begin
            in_blank = 1'b1;
            if (!cen.p6_n)
                blank_p6++;
        end
        else if (in_blank)
            blank_done = 1'b1;  // Back to visible lines
    end
end

always @(posedge mclk)
begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
        $display("timeout: run stopped after %0d MCLK cycles without finishing", cycle_cnt);
        $display("Simulation failed");
        $finish;
    end
end

//////////////////////////////////////////////////
// Test sequence
//////////////////////////////////////////////////

initial
begin
    cpu_req = '0;
    cpu_cs  = CS_NONE;
    seed    = 32'heb53_52fe;
    wait (arst_n === 1'b1);
    run_enable_test();
    fill_rams();
    fetch_on = 1'b1;
    run_vram_test();
    run_scroll_test();
    wait (blank_done);              // Frame timing limited by the cycle counter
    if (fetch_checks == 0)
    begin
        $display("error: no fetch record was seen after the RAM fill");
        fetch_errs++;
    end
    report_test("fetch_contents", fetch_checks, fetch_errs);
    check_count(blank_p6, (`VID_V_TOTAL - `VID_V_ACTIVE) * `VID_H_TOTAL,
                "6 MHz enables in vertical blank", blank_errs);
    report_test("vblank_length", 1, blank_errs);
    $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0)
        $display("Simulation completed successfully");
    else
        $display("Simulation failed");
    $finish;
end

endmodule

`default_nettype wire

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
(
    output logic    o_clk,
    output logic    o_arst_n
);

// 125 MHz master clock, 8 ns period
initial
begin
    o_clk = 1'b0;
    forever #4 o_clk = ~o_clk;
end

// Reset held for two cycles, released on a falling edge
initial
begin
    o_arst_n = 1'b0;
    repeat(2) @(posedge o_clk);
    @(negedge o_clk);
    o_arst_n = 1'b1;
end

endmodule

`default_nettype wire
